//--- Makefile
# Verilator build and run of the accumulator CPU testbench

SOURCES := $(wildcard hw/*.sv bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vasrm_tb: tb.f $(SOURCES)
	verilator --binary --assert --top-module asrm_tb -f tb.f

run: obj_dir/Vasrm_tb
	@out="$$(./obj_dir/Vasrm_tb)"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

//--- bench/asrm_properties.sv
/* Bus and register role assertions for the accumulator CPU core
   Bound into every asrm_cpu instance */

`timescale 1ns/1ps

module asrm_properties
    import asrm_bus_pkg::*;
#(
    parameter int wordsize = default_word_width
)(
    input logic                clk,
    input logic                reset,
    input logic                write_en,
    input logic                quit,
    input logic                ram_not_ready,
    input logic [wordsize-1:0] pc
);

    int failures = 0;  // Failed assertion count

    // Store and push write for a single cycle
    write_pulse: assert property (@(posedge clk) disable iff (!reset) write_en |=> !write_en)
        else
        begin
            failures++;
            $error("write_en stayed high for more than one cycle");
        end

    // Halted core stays halted until reset
    quit_sticky: assert property (@(posedge clk) disable iff (!reset) quit |=> quit)
        else
        begin
            failures++;
            $error("quit fell while reset was released");
        end

    pc_on_retire: assert property (@(posedge clk) disable iff (!reset)
        ram_not_ready |=> $stable(pc))
        else
        begin
            failures++;
            $error("pc changed outside a retire cycle");
        end

endmodule

bind asrm_cpu asrm_properties #(.wordsize(wordsize)) i_props (
    .clk           (clk),
    .reset         (reset),
    .write_en      (write_en),
    .quit          (quit),
    .ram_not_ready (ram_not_ready),
    .pc            (pc)
);

//--- bench/asrm_tb.sv
/* Testbench for the accumulator CPU system
   Runs random programs and compares the final memory with an ISA model */

`timescale 1ns/1ps

module asrm_tb
    import asrm_isa_pkg::*, asrm_bus_pkg::*;
();

    localparam int          word_w     = default_word_width;
    localparam int          addr_w     = default_mem_addr_width;
    localparam int          mem_words  = 2 ** addr_w;
    localparam int          clk_period = 40;
    localparam int          num_tests  = 40;
    localparam int          max_instr  = 128;
    localparam int          prog_start = 32;   // Words 4 to 31 hold the stack
    localparam int          data_start = 128;
    localparam int          body_end   = data_start - 10;
    localparam logic [31:0] seed       = 32'hb509_217c;
    // Execution at 4 cycles per instruction, plus load and readback of memory
    localparam int          test_cycles = max_instr * 4 + 3 * mem_words + 128;

    logic              clk;
    logic              reset;
    logic              ext_we;
    logic [addr_w-1:0] ext_addr;
    logic [word_w-1:0] ext_wdata;
    logic [word_w-1:0] ext_rdata;
    logic              quit;

    logic [word_w-1:0] image [mem_words];      // Program and data as loaded
    logic [word_w-1:0] model_mem [mem_words];  // Memory after the model run
    int                pos;
    int                errors;

    asrm_system #(
        .wordsize       (word_w),
        .mem_addr_width (addr_w)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .ext_we    (ext_we),
        .ext_addr  (ext_addr),
        .ext_wdata (ext_wdata),
        .ext_rdata (ext_rdata),
        .quit      (quit)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [7:0] encode(input opcode_t op, input logic [3:0] arg);
        return {op, arg};
    endfunction

    function automatic logic [3:0] pick_pointer();
        return 4'(8 + $urandom_range(3));  // r8 to r11 point into data
    endfunction

    task automatic emit(input logic [7:0] ins);
        image[pos] = {8'($urandom), ins};  // Upper byte ignored by the core
        pos++;
    endtask

    task automatic build_program();
        opcode_t    op;
        logic [3:0] arg;
        int         sp_val;
        int         choice;
        int         target;
        for (int a = 0; a < mem_words; a++)
            image[a] = word_w'($urandom);
        // Entry jump over the stack area relies on sr resetting to 1
        pos = 0;
        emit(encode(setn, 4'(prog_start / 16)));
        emit(encode(setn, 4'(prog_start % 16)));
        emit(encode(jmp, wr_id));
        pos = prog_start;
        for (int k = 8; k < 12; k++)
        begin
            emit(encode(xor_op, wr_id));  // Clear wr
            emit(encode(setn, 4'(8 + $urandom_range(7))));
            emit(encode(setn, 4'($urandom)));
            emit(encode(movt, 4'(k)));
        end
        sp_val = sp_reset;
        while (pos < body_end)
        begin
            choice = $urandom_range(9);
            if (choice < 4)
            begin
                op = opcode_t'(4'($urandom_range(8, 1)));  // add up to setn
                if (op == movt)
                    arg = 4'($urandom_range(7));  // Leave pointers and fixed roles
                else
                    arg = 4'($urandom);
                emit(encode(op, arg));
                emit(encode(store, pick_pointer()));
            end
            else if (choice == 4)
                emit(encode(load, pick_pointer()));
            else if (choice == 5)
            begin
                target = pos + 8;  // Just past the store that may be skipped
                emit(encode(xor_op, wr_id));
                emit(encode(setn, 4'(target / 16)));
                emit(encode(setn, 4'(target % 16)));
                emit(encode(movt, 4'd6));
                emit(encode(movf, 4'($urandom_range(11))));
                emit(encode(cmp, 4'($urandom_range(11))));
                emit(encode(jmp, 4'd6));
                emit(encode(store, pick_pointer()));
            end
            else if (choice < 8 && sp_val < prog_start)
            begin
                emit(encode(special, arg_push));
                sp_val++;
            end
            else if (choice >= 8 && sp_val > sp_reset)
            begin
                emit(encode(special, arg_pop));
                emit(encode(store, pick_pointer()));
                sp_val--;
            end
        end
        emit(encode(special, arg_quit));
        emit(encode(store, pick_pointer()));  // Lies behind quit
    endtask

    // Instruction set reference stepping one instruction at a time
    task automatic run_model(input int t);
        logic [word_w-1:0] r [16];
        logic [word_w-1:0] next_pc;
        logic [word_w-1:0] ra;
        logic [7:0]        ins;
        logic [3:0]        a;
        bit                done;
        int                steps;
        done  = 1'b0;
        steps = 0;
        for (int i = 0; i < 16; i++)
            r[i] = '0;
        r[sr_id] = word_w'(sr_reset);
        r[sp_id] = word_w'(sp_reset);
        for (int i = 0; i < mem_words; i++)
            model_mem[i] = image[i];
        while (!done && steps < 2 * max_instr)
        begin
            ins     = model_mem[r[pc_id][addr_w-1:0]][7:0];
            a       = ins[3:0];
            ra      = r[a];
            next_pc = r[pc_id] + 1'b1;
            steps++;
            case (opcode_t'(ins[7:4]))
                add:    r[wr_id] = r[wr_id] + ra;
                sub:    r[wr_id] = r[wr_id] - ra;
                and_op: r[wr_id] = r[wr_id] & ra;
                or_op:  r[wr_id] = r[wr_id] | ra;
                xor_op: r[wr_id] = r[wr_id] ^ ra;
                movf:   r[wr_id] = ra;
                movt:
                    if (a == pc_id)
                        next_pc = r[wr_id];
                    else
                        r[a] = r[wr_id];
                setn:   r[wr_id] = {r[wr_id][word_w-5:0], a};
                cmp:    r[sr_id] = (r[wr_id] < ra) ? word_w'(1) : word_w'(0);
                jmp:
                    if (r[sr_id][0])
                        next_pc = ra;
                load:   r[wr_id] = model_mem[ra[addr_w-1:0]];
                store:  model_mem[ra[addr_w-1:0]] = r[wr_id];
                special:
                    if (a == arg_push)
                    begin
                        model_mem[r[sp_id][addr_w-1:0]] = r[wr_id];
                        r[sp_id] = r[sp_id] + 1'b1;
                    end
                    else if (a == arg_pop)
                    begin
                        r[sp_id] = r[sp_id] - 1'b1;
                        r[wr_id] = model_mem[r[sp_id][addr_w-1:0]];
                    end
                    else if (a == arg_quit)
                        done = 1'b1;
                default: ;  // nop and unused opcodes
            endcase
            r[pc_id] = next_pc;
        end
        if (!done)
        begin
            errors++;
            $display("Model of test %0d did not reach quit within %0d steps", t, steps);
        end
    endtask

    task automatic run_program(input int t);
        @(posedge clk);
        reset <= 1'b0;
        repeat (5) @(posedge clk);
        for (int a = 0; a < mem_words; a++)
        begin
            ext_we    <= 1'b1;
            ext_addr  <= addr_w'(a);
            ext_wdata <= image[a];
            @(posedge clk);
        end
        ext_we <= 1'b0;
        reset  <= 1'b1;
        @(negedge clk);
        check_value($sformatf("test %0d quit after reset", t), 0, quit);
        while (quit !== 1'b1)
            @(negedge clk);
        // Memory must keep its state at quit while the halted core idles
        repeat (8) @(posedge clk);
    endtask

    task automatic compare_memory(input int t);
        for (int a = 0; a < mem_words; a++)
        begin
            @(posedge clk);
            ext_addr <= addr_w'(a);
            @(posedge clk);
            @(negedge clk);  // Port B word of the previous edge
            check_value($sformatf("test %0d mem[%0d]", t, a), model_mem[a], ext_rdata);
        end
        check_value($sformatf("test %0d quit held", t), 1, quit);
    endtask

    initial
    begin
        void'($urandom(seed));
        errors    = 0;
        clk       = 1'b0;
        reset     = 1'b0;
        ext_we    = 1'b0;
        ext_addr  = '0;
        ext_wdata = '0;
        for (int t = 0; t < num_tests; t++)
        begin
            build_program();
            run_model(t);
            run_program(t);
            compare_memory(t);
        end
        $display("Tests run %0d, check errors %0d, assertion failures %0d",
                 num_tests, errors, i_dut.cpu.i_props.failures);
        if (errors == 0 && i_dut.cpu.i_props.failures == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial
    begin
        #(num_tests * test_cycles * clk_period);
        $display("Watchdog expired, the CPU did not reach quit in time");
        $display("Verification failed");
        $finish;
    end

endmodule

//--- hw/asrm_addr.sv
/* Memory access unit
   Fetches instructions, holds the instruction register and runs
   the load, store, push and pop bus cycles */

`timescale 1ns/1ps

module asrm_addr
    import asrm_isa_pkg::*, asrm_bus_pkg::*;
#(
    parameter int wordsize = default_word_width
)(
    input  logic                clk,
    input  logic                reset,
    input  logic [wordsize-1:0] wr,
    input  logic [wordsize-1:0] pc,
    input  logic [wordsize-1:0] sp,
    input  logic [wordsize-1:0] arg_reg,
    input  logic [wordsize-1:0] data_in,
    input  logic                halt,
    output logic [7:0]          instruction,
    output logic [wordsize-1:0] addr,
    output logic [wordsize-1:0] data_out,
    output logic                write_en,
    output logic [wordsize-1:0] content,
    output logic [3:0]          index,
    output logic                wen,
    output logic                ram_not_ready
);

    access_kind_t kind;
    access_kind_t decoded;
    logic         phase;  // Second cycle of a two-cycle access
    logic [7:0]   ir;
    logic         fetch_done;

    assign fetch_done  = (kind == acc_fetch) && phase;
    assign instruction = fetch_done ? data_in[7:0] : ir;  // Bypass on the fetch cycle
    assign data_out    = wr;

    // Which access follows the fetch
    always_comb
    begin
        decoded = acc_fetch;
        case (opcode_t'(instruction[7:4]))
            load:  decoded = acc_load;
            store: decoded = acc_store;
            special:
                if (instruction[3:0] == arg_push)
                    decoded = acc_push;
                else if (instruction[3:0] == arg_pop)
                    decoded = acc_pop;
            default: ;
        endcase
    end

    always_comb
    begin
        addr          = pc;
        write_en      = 1'b0;
        content       = data_in;
        index         = wr_id;
        wen           = 1'b0;
        ram_not_ready = 1'b1;
        case (kind)
            acc_fetch: ram_not_ready = !(phase && decoded == acc_fetch);
            acc_store:
            begin
                addr          = arg_reg;
                write_en      = 1'b1;
                ram_not_ready = 1'b0;
            end
            acc_push:
            begin
                addr          = sp;
                write_en      = !phase;
                ram_not_ready = !phase;
            end
            acc_load, acc_pop:
            begin
                addr          = (kind == acc_pop) ? sp - 1'b1 : arg_reg;
                wen           = phase;  // Read word goes to wr
                ram_not_ready = !phase;
            end
            default: ;  // Halted
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            kind  <= acc_fetch;
            phase <= 1'b0;
        end
        else
        begin
            case (kind)
                acc_fetch:
                    if (!phase)
                    begin
                        if (halt)
                            kind <= acc_none;  // Quit has retired
                        else
                            phase <= 1'b1;
                    end
                    else
                    begin
                        kind  <= decoded;
                        phase <= 1'b0;
                    end
                acc_store: kind <= acc_fetch;
                acc_load, acc_push, acc_pop:
                begin
                    if (phase)
                        kind <= acc_fetch;
                    phase <= !phase;
                end
                default: ;  // Stays halted until reset
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_done)
            ir <= data_in[7:0];
    end

endmodule

//--- hw/asrm_alu.sv
/* ALU of the accumulator CPU
   Decodes the register instructions into a write index, value and enable */

`timescale 1ns/1ps

module asrm_alu
    import asrm_isa_pkg::*;
#(
    parameter int wordsize = 16
)(
    input  logic [wordsize-1:0] wr,
    input  logic [wordsize-1:0] arg_reg,
    input  logic [wordsize-1:0] sr,
    input  logic [7:0]          instruction,
    output logic [wordsize-1:0] content,
    output logic [3:0]          index,
    output logic                wen
);

    opcode_t    op;
    logic [3:0] arg_id;

    assign op     = opcode_t'(instruction[7:4]);
    assign arg_id = instruction[3:0];

    always_comb
    begin
        // Most instructions write the working register
        content = wr;
        index   = wr_id;
        wen     = 1'b1;
        case (op)
            add:    content = wr + arg_reg;
            sub:    content = wr - arg_reg;
            and_op: content = wr & arg_reg;
            or_op:  content = wr | arg_reg;
            xor_op: content = wr ^ arg_reg;
            movf:   content = arg_reg;
            movt:   index   = arg_id;  // Value stays wr
            setn:   content = {wr[wordsize-5:0], arg_id};
            cmp:
            begin
                index   = sr_id;
                content = wordsize'(wr < arg_reg);
            end
            jmp:
            begin
                index   = pc_id;
                content = arg_reg;
                wen     = sr[0];  // Not taken leaves pc to the increment
            end
            default: wen = 1'b0;  // nop, load, store and special
        endcase
    end

endmodule

//--- hw/asrm_bus_pkg.sv
/* Memory bus definitions
   Kinds of bus cycle and the default word and address widths */

package asrm_bus_pkg;

    // What the memory unit is doing on the bus
    typedef enum logic [2:0] {
        acc_none  = 3'd0,
        acc_fetch = 3'd1,
        acc_load  = 3'd2,
        acc_store = 3'd3,
        acc_push  = 3'd4,
        acc_pop   = 3'd5
    } access_kind_t;

    localparam int default_word_width     = 16;
    localparam int default_mem_addr_width = 8;  // 256 words

endpackage

//--- hw/asrm_cpu.sv
/* Accumulator CPU core
   Register file with pc and sp update, joins the ALU and the memory unit */

`timescale 1ns/1ps

module asrm_cpu
    import asrm_isa_pkg::*;
#(
    parameter int wordsize = 16
)(
    input  logic                clk,
    input  logic                reset,
    input  logic [wordsize-1:0] data_in,
    output logic                quit,
    output logic [wordsize-1:0] addr,
    output logic [wordsize-1:0] data_out,
    output logic                write_en
);

    logic [wordsize-1:0] regs [16];
    logic [wordsize-1:0] wr;
    logic [wordsize-1:0] sr;
    logic [wordsize-1:0] sp;
    logic [wordsize-1:0] pc;
    logic [wordsize-1:0] arg_reg;
    logic [7:0]          instruction;
    logic                ram_not_ready;

    logic [wordsize-1:0] content_alu;
    logic [wordsize-1:0] content_addr;
    logic [wordsize-1:0] content;
    logic [3:0]          index_alu;
    logic [3:0]          index_addr;
    logic [3:0]          index;
    logic                wen_alu;
    logic                wen_addr;
    logic                wen;

    logic                is_special;
    logic                is_push;
    logic                is_pop;
    logic                is_quit;

    assign wr      = regs[wr_id];
    assign sr      = regs[sr_id];
    assign sp      = regs[sp_id];
    assign pc      = regs[pc_id];
    assign arg_reg = regs[instruction[3:0]];

    // Only one path writes per instruction
    assign wen     = wen_alu | wen_addr;
    assign content = wen_addr ? content_addr : content_alu;
    assign index   = wen_addr ? index_addr : index_alu;

    assign is_special = opcode_t'(instruction[7:4]) == special;
    assign is_push    = is_special && instruction[3:0] == arg_push;
    assign is_pop     = is_special && instruction[3:0] == arg_pop;
    assign is_quit    = is_special && instruction[3:0] == arg_quit;

    asrm_alu #(.wordsize(wordsize)) alu (
        .wr          (wr),
        .arg_reg     (arg_reg),
        .sr          (sr),
        .instruction (instruction),
        .content     (content_alu),
        .index       (index_alu),
        .wen         (wen_alu)
    );

    asrm_addr #(.wordsize(wordsize)) mem_unit (
        .clk           (clk),
        .reset         (reset),
        .wr            (wr),
        .pc            (pc),
        .sp            (sp),
        .arg_reg       (arg_reg),
        .data_in       (data_in),
        .halt          (quit),
        .instruction   (instruction),
        .addr          (addr),
        .data_out      (data_out),
        .write_en      (write_en),
        .content       (content_addr),
        .index         (index_addr),
        .wen           (wen_addr),
        .ram_not_ready (ram_not_ready)
    );

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
            regs[sr_id] <= wordsize'(sr_reset);
            regs[sp_id] <= wordsize'(sp_reset);
            quit        <= 1'b0;
        end
        else if (!ram_not_ready)  // Retire cycle
        begin
            if (is_quit)
                quit <= 1'b1;
            if (!(wen && index == pc_id))
                regs[pc_id] <= pc + 1'b1;
            if (wen)
                regs[index] <= content;  // A jump overrides the increment
            if (is_push)
                regs[sp_id] <= sp + 1'b1;
            else if (is_pop)
                regs[sp_id] <= sp - 1'b1;
        end
    end

endmodule

//--- hw/asrm_isa_pkg.sv
/* Instruction set of the accumulator CPU
   Opcodes, special arguments and the fixed register roles */

package asrm_isa_pkg;

    // Upper nibble of the 8-bit instruction
    typedef enum logic [3:0] {
        nop     = 4'd0,
        add     = 4'd1,
        sub     = 4'd2,
        and_op  = 4'd3,
        or_op   = 4'd4,
        xor_op  = 4'd5,
        movf    = 4'd6,   // wr takes rA
        movt    = 4'd7,   // rA takes wr
        setn    = 4'd8,   // Shift wr one nibble, insert argument
        cmp     = 4'd9,   // sr = wr < rA, unsigned
        jmp     = 4'd10,  // Taken when sr bit 0 set
        load    = 4'd11,
        store   = 4'd12,
        special = 4'd15
    } opcode_t;

    // Lower nibble when opcode is special
    localparam logic [3:0] arg_push = 4'd0;
    localparam logic [3:0] arg_pop  = 4'd1;
    localparam logic [3:0] arg_quit = 4'd15;

    // Registers with a fixed role
    localparam logic [3:0] wr_id = 4'd12;
    localparam logic [3:0] sr_id = 4'd13;
    localparam logic [3:0] sp_id = 4'd14;
    localparam logic [3:0] pc_id = 4'd15;

    // Reset values, all other registers clear to 0
    localparam int sr_reset = 1;
    localparam int sp_reset = 4;

endpackage

//--- hw/asrm_ram.sv
/* Dual-port word RAM for program and data
   Port A serves the CPU, port B the external load and readback port */

`timescale 1ns/1ps

module asrm_ram
    import asrm_bus_pkg::*;
#(
    parameter int wordsize       = default_word_width,
    parameter int mem_addr_width = default_mem_addr_width
)(
    input  logic                      clk,
    input  logic [mem_addr_width-1:0] addr_a,
    input  logic [wordsize-1:0]       wdata_a,
    input  logic                      we_a,
    output logic [wordsize-1:0]       rdata_a,
    input  logic [mem_addr_width-1:0] addr_b,
    input  logic [wordsize-1:0]       wdata_b,
    input  logic                      we_b,
    output logic [wordsize-1:0]       rdata_b
);

    localparam int depth = 2 ** mem_addr_width;

    // Instructions sit in the low byte of a word
    logic [wordsize-1:0] mem [depth];

    always_ff @(posedge clk)
    begin
        if (we_a)
            mem[addr_a] <= wdata_a;
        if (we_b)
            mem[addr_b] <= wdata_b;  // Port B wins on the same address
    end

    // One cycle read latency, old data during a write
    always_ff @(posedge clk)
    begin
        rdata_a <= mem[addr_a];
        rdata_b <= mem[addr_b];
    end

endmodule

//--- hw/asrm_system.sv
/* Top level of the accumulator CPU system
   Connects the core to port A of the RAM, port B goes outside */

`timescale 1ns/1ps

module asrm_system
    import asrm_bus_pkg::*;
#(
    parameter int wordsize       = default_word_width,
    parameter int mem_addr_width = default_mem_addr_width
)(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ext_we,
    input  logic [mem_addr_width-1:0] ext_addr,
    input  logic [wordsize-1:0]       ext_wdata,
    output logic [wordsize-1:0]       ext_rdata,
    output logic                      quit
);

    logic [wordsize-1:0] cpu_addr;
    logic [wordsize-1:0] cpu_wdata;
    logic [wordsize-1:0] cpu_rdata;
    logic                cpu_we;

    asrm_cpu #(.wordsize(wordsize)) cpu (
        .clk      (clk),
        .reset    (reset),
        .data_in  (cpu_rdata),
        .quit     (quit),
        .addr     (cpu_addr),
        .data_out (cpu_wdata),
        .write_en (cpu_we)
    );

    asrm_ram #(
        .wordsize       (wordsize),
        .mem_addr_width (mem_addr_width)
    ) ram (
        .clk     (clk),
        .addr_a  (cpu_addr[mem_addr_width-1:0]),  // Word address wraps at the RAM size
        .wdata_a (cpu_wdata),
        .we_a    (cpu_we),
        .rdata_a (cpu_rdata),
        .addr_b  (ext_addr),
        .wdata_b (ext_wdata),
        .we_b    (ext_we),
        .rdata_b (ext_rdata)
    );

endmodule

//--- tb.f
hw/asrm_isa_pkg.sv
hw/asrm_bus_pkg.sv
hw/asrm_alu.sv
hw/asrm_addr.sv
hw/asrm_cpu.sv
hw/asrm_ram.sv
hw/asrm_system.sv
bench/asrm_properties.sv
bench/asrm_tb.sv
